// ==== bench/isaModel.sv ====
`default_nettype none

`include "core_consts.svh"

module isaModel;

  import core_pkg::*;

  localparam int ProgLen = 96;
  localparam int ExpMax  = 128;

  // program image and the data memory it starts from
  instrT              prog [ProgLen];
  logic [`DATA_W-1:0] dataInit [64];

  // expected register writes and stores, in program order
  logic [3:0]         expWrRd [ExpMax];
  logic [`DATA_W-1:0] expWrData [ExpMax];
  logic [`DATA_W-1:0] expStAddr [ExpMax];
  logic [`DATA_W-1:0] expStData [ExpMax];
  int                 expWrCnt;
  int                 expStCnt;
  // instructions executed before the final loop
  int                 execCnt;
  logic               ready;

  // one random instruction for slot idx
  function automatic instrT randInstr(int idx);
    instrT w;
    int    pick;
    int    span;
    w    = '0;
    pick = $urandom_range(11, 0);
    if (pick >= 10 && idx <= ProgLen - 3)
    begin
      // forward only, target no later than the final loop
      span     = ProgLen - 3 - idx;
      w.br.cls = `CLASS_BR;
      case ($urandom_range(2, 0))
        0:       w.br.cond = `COND_AL;
        1:       w.br.cond = `COND_EQ;
        default: w.br.cond = `COND_NE;
      endcase
      w.br.offset = $urandom_range((span < 3) ? span : 3, 0);
    end
    else if (pick >= 7)
    begin
      w.mem.cond   = `COND_AL;
      w.mem.cls    = `CLASS_MEM;
      w.mem.isLoad = (pick <= 8);
      w.mem.rn     = $urandom_range(7, 0);
      w.mem.rd     = $urandom_range(7, 0);
      w.mem.offset = $urandom_range(4095, 0);
    end
    else
    begin
      w.dp.cond  = `COND_AL;
      w.dp.cls   = `CLASS_DP;
      w.dp.isImm = $urandom_range(1, 0);
      case (pick % 6)
        0:       w.dp.opcode = `OP_ADD;
        1:       w.dp.opcode = `OP_SUB;
        2:       w.dp.opcode = `OP_AND;
        3:       w.dp.opcode = `OP_ORR;
        4:       w.dp.opcode = `OP_MOV;
        default: w.dp.opcode = `OP_CMP;
      endcase
      w.dp.rn = $urandom_range(7, 0);
      w.dp.rd = $urandom_range(7, 0);
      // register form keeps rm in the low nibble
      w.dp.op2 = w.dp.isImm ? $urandom_range(255, 0) : $urandom_range(7, 0);
    end
    return w;
  endfunction

  task automatic addWrite(input logic [3:0] rd, input logic [`DATA_W-1:0] val);
    expWrRd[expWrCnt]   = rd;
    expWrData[expWrCnt] = val;
    expWrCnt++;
  endtask

  initial
  begin : runModel
    logic [`DATA_W-1:0] regs [16];
    logic [`DATA_W-1:0] mem [64];
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] addr;
    logic               z;
    int                 pc;
    instrT              w;
    ready    = 1'b0;
    expWrCnt = 0;
    expStCnt = 0;
    execCnt  = 0;
    void'($urandom(32'h4ad6_4b31));
    for (int i = 0; i < 64; i++)
    begin
      dataInit[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
      mem[i]      = dataInit[i];
    end
    for (int i = 0; i < ProgLen - 1; i++)
      prog[i] = randInstr(i);
    // last word branches to itself, offset -2 words
    prog[ProgLen - 1]           = '0;
    prog[ProgLen - 1].br.cond   = `COND_AL;
    prog[ProgLen - 1].br.cls    = `CLASS_BR;
    prog[ProgLen - 1].br.offset = 24'hff_fffe;
    for (int r = 0; r < 16; r++)
      regs[r] = '0;
    z  = 1'b0;
    pc = 0;
    // plain sequential execution until the final loop
    while (pc != ProgLen - 1)
    begin
      w = prog[pc];
      execCnt++;
      pc++;
      case (w.dp.cls)
        `CLASS_DP:
        begin
          a = regs[w.dp.rn];
          b = w.dp.isImm ? {24'h0, w.dp.op2} : regs[w.dp.op2[3:0]];
          case (w.dp.opcode)
            `OP_ADD: a = a + b;
            `OP_SUB: a = a - b;
            `OP_AND: a = a & b;
            `OP_ORR: a = a | b;
            `OP_MOV: a = b;
            // cmp sets Z when the difference is zero
            default: z = (a == b);
          endcase
          if (w.dp.opcode != `OP_CMP)
          begin
            regs[w.dp.rd] = a;
            addWrite(w.dp.rd, a);
          end
        end
        `CLASS_MEM:
        begin
          // 64-word data region, word index from address bits 7:2
          addr = regs[w.mem.rn] + w.mem.offset;
          if (w.mem.isLoad)
          begin
            regs[w.mem.rd] = mem[addr[7:2]];
            addWrite(w.mem.rd, regs[w.mem.rd]);
          end
          else
          begin
            mem[addr[7:2]]      = regs[w.mem.rd];
            expStAddr[expStCnt] = addr;
            expStData[expStCnt] = regs[w.mem.rd];
            expStCnt++;
          end
        end
        default:
        begin
          // target is two words past the branch plus the offset
          if ((w.br.cond == `COND_AL) || (w.br.cond == `COND_EQ && z) ||
              (w.br.cond == `COND_NE && !z))
            pc = pc + 1 + w.br.offset;
        end
      endcase
    end
    ready = 1'b1;
  end

endmodule

`default_nettype wire

// ==== bench/tbCore.sv ====
`default_nettype none

`include "core_consts.svh"

module tbCore;

  import core_pkg::*;

  localparam int ProgLen = 96;
  // byte address of the final branch-to-self
  localparam logic [`DATA_W-1:0] LastPc = (ProgLen - 1) * 4;

  logic               clk;
  logic               rstN;
  logic [`DATA_W-1:0] iAddr;
  instrT              iData;
  dReqT               dReq;
  logic [`DATA_W-1:0] dRData;
  logic               dStall;
  wbRptT              wbRpt;

  // instruction and data memories
  instrT              iMem [128];
  logic [`DATA_W-1:0] dMem [64];

  int                 wrIdx;
  int                 stIdx;
  int                 valueErrs;
  int                 otherErrs;
  int                 sinceReset;
  logic               stallPrev;
  dReqT               reqPrev;

  pipeCore pipeCore_i (
    .clk    (clk),
    .rstN   (rstN),
    .iAddr  (iAddr),
    .iData  (iData),
    .dReq   (dReq),
    .dRData (dRData),
    .dStall (dStall),
    .wbRpt  (wbRpt)
  );

  isaModel isaModel_i ();

  initial
  begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  // both memories answer in the same cycle
  assign iData  = iMem[iAddr[8:2]];
  assign dRData = dMem[dReq.addr[7:2]];

  // random data stalls, about one cycle in five
  always @(posedge clk)
  begin
    #1;
    dStall = ($urandom_range(4, 0) == 0);
  end

  task automatic checkWrite();
    if (wrIdx >= isaModel_i.expWrCnt)
    begin
      $display("t=%0t register write to r%0d past the end of the program", $time, wbRpt.rd);
      otherErrs++;
    end
    else
    begin
      if (wbRpt.rd !== isaModel_i.expWrRd[wrIdx])
      begin
        $display("ERR t=%0t wbRpt.rd got %0d exp %0d", $time, wbRpt.rd,
                 isaModel_i.expWrRd[wrIdx]);
        valueErrs++;
      end
      if (wbRpt.data !== isaModel_i.expWrData[wrIdx])
      begin
        $display("ERR t=%0t wbRpt.data got %h exp %h", $time, wbRpt.data,
                 isaModel_i.expWrData[wrIdx]);
        valueErrs++;
      end
      wrIdx++;
    end
  endtask

  task automatic checkStore();
    if (stIdx >= isaModel_i.expStCnt)
    begin
      $display("t=%0t store to %h past the end of the program", $time, dReq.addr);
      otherErrs++;
    end
    else
    begin
      if (dReq.addr !== isaModel_i.expStAddr[stIdx])
      begin
        $display("ERR t=%0t dReq.addr got %h exp %h", $time, dReq.addr,
                 isaModel_i.expStAddr[stIdx]);
        valueErrs++;
      end
      if (dReq.wdata !== isaModel_i.expStData[stIdx])
      begin
        $display("ERR t=%0t dReq.wdata got %h exp %h", $time, dReq.wdata,
                 isaModel_i.expStData[stIdx]);
        valueErrs++;
      end
      stIdx++;
    end
    // memory follows what the core actually wrote
    dMem[dReq.addr[7:2]] = dReq.wdata;
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk)
  begin
    // nothing reaches M or W in the first cycles out of reset
    if ((!rstN || sinceReset < 3) && (dReq.valid !== 1'b0 || wbRpt.valid !== 1'b0))
    begin
      $display("t=%0t memory or writeback strobe active right after reset", $time);
      otherErrs++;
    end
    if (rstN)
    begin
      if (wbRpt.valid)
        checkWrite();
      if (dReq.valid && dReq.write && !dStall)
        checkStore();
      // a stalled request must not move
      if (stallPrev && dReq !== reqPrev)
      begin
        $display("ERR t=%0t dReq got %h exp %h", $time, dReq, reqPrev);
        valueErrs++;
      end
      stallPrev = dStall;
      reqPrev   = dReq;
      sinceReset++;
    end
  end

  task automatic closeRun();
    $display("writes %0d/%0d stores %0d/%0d value errors %0d other errors %0d",
             wrIdx, isaModel_i.expWrCnt, stIdx, isaModel_i.expStCnt, valueErrs, otherErrs);
    if (valueErrs == 0 && otherErrs == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  endtask

  initial
  begin
    rstN       = 1'b0;
    dStall     = 1'b0;
    wrIdx      = 0;
    stIdx      = 0;
    valueErrs  = 0;
    otherErrs  = 0;
    sinceReset = 0;
    stallPrev  = 1'b0;
    reqPrev    = '0;
    wait (isaModel_i.ready === 1'b1);
    // words past the program differ by address, only fetched on the wrong path
    for (int i = 0; i < 128; i++)
      iMem[i] = 32'he000_0000 | i;
    for (int i = 0; i < ProgLen; i++)
      iMem[i] = isaModel_i.prog[i];
    for (int i = 0; i < 64; i++)
      dMem[i] = isaModel_i.dataInit[i];
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    // done once every expected write and store has been seen
    while (wrIdx < isaModel_i.expWrCnt || stIdx < isaModel_i.expStCnt)
      @(negedge clk);
    // core spins on the last branch, nothing more may come out
    repeat (16) @(negedge clk);
    if (iAddr < LastPc || iAddr > LastPc + 8)
    begin
      $display("t=%0t fetch left the final branch loop at %h", $time, iAddr);
      otherErrs++;
    end
    closeRun();
  end

  // budget of 20 cycles per executed instruction, plus reset and tail
  initial
  begin
    wait (isaModel_i.ready === 1'b1);
    repeat (20 * isaModel_i.execCnt + 20) @(posedge clk);
    $display("timeout, expected writes or stores never arrived");
    otherErrs++;
    closeRun();
  end

endmodule

`default_nettype wire

// ==== include/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data and instruction word width
`define DATA_W 32
// architectural registers, numbered with 4 bits
`define REG_CNT 16

// data-processing opcodes, ARM encodings
`define OP_AND 4'b0000
`define OP_SUB 4'b0010
`define OP_ADD 4'b0100
`define OP_CMP 4'b1010
`define OP_ORR 4'b1100
`define OP_MOV 4'b1101

// instruction class in bits 27:26
`define CLASS_DP  2'b00
`define CLASS_MEM 2'b01
`define CLASS_BR  2'b10

// branch conditions, tested against Z only
`define COND_EQ 4'b0000
`define COND_NE 4'b0001
`define COND_AL 4'b1110

`endif

// ==== rtl/alu.sv ====
`default_nettype none

`include "core_consts.svh"

module alu (
  input  wire logic [`DATA_W-1:0] a,
  input  wire logic [`DATA_W-1:0] b,
  input  wire core_pkg::aluOpT    op,
  output logic      [`DATA_W-1:0] y,
  output logic                    zero
);

  import core_pkg::*;

  always_comb
  begin
    case (op)
      ALU_ADD:
        y = a + b;
      // cmp goes through here as well
      ALU_SUB:
        y = a - b;
      ALU_AND:
        y = a & b;
      ALU_ORR:
        y = a | b;
      // mov passes the second operand
      ALU_PASSB:
        y = b;
      default:
        y = '0;
    endcase
  end

  // Z for cmp, meaningful only on subtract
  assign zero = (y == '0);

endmodule

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

`include "core_consts.svh"

package core_pkg;

  // data-processing view
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] cls;
    logic       isImm;
    logic [3:0] opcode;
    logic       unused0;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] unused1;
    // register number in [3:0] or 8-bit immediate
    logic [7:0] op2;
  } dpFmtT;

  // load/store view
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  cls;
    logic        isLoad;
    logic [4:0]  unused;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } memFmtT;

  // branch view, offset counts words
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  cls;
    logic [1:0]  unused;
    logic [23:0] offset;
  } brFmtT;

  // one fetched word, three ways to read it
  typedef union packed {
    dpFmtT  dp;
    memFmtT mem;
    brFmtT  br;
  } instrT;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_ORR,
    ALU_PASSB
  } aluOpT;

  typedef struct packed {
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       branch;
    logic       setFlag;
    logic       useImm;
    aluOpT      aluOp;
    logic [3:0] cond;
  } deCtrlT;

  // decode/execute register
  typedef struct packed {
    deCtrlT             ctrl;
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] rnVal;
    logic [`DATA_W-1:0] rmVal;
    logic [`DATA_W-1:0] imm;
    logic [3:0]         rn;
    logic [3:0]         rm;
    logic [3:0]         rd;
  } idExT;

  // execute/memory register
  typedef struct packed {
    logic               regWrite;
    logic               memRead;
    logic               memWrite;
    logic [`DATA_W-1:0] aluRes;
    logic [`DATA_W-1:0] storeData;
    logic [3:0]         rd;
  } exMemT;

  // memory/writeback register
  typedef struct packed {
    logic               regWrite;
    logic [`DATA_W-1:0] result;
    logic [3:0]         rd;
  } memWbT;

  typedef struct packed {
    logic [3:0] rnD;
    logic [3:0] rmD;
    logic       usesRnD;
    logic       usesRmD;
    logic [3:0] rnE;
    logic [3:0] rmE;
    logic [3:0] rdE;
    logic       memReadE;
    logic [3:0] rdM;
    logic       regWriteM;
    logic [3:0] rdW;
    logic       regWriteW;
    logic       branchTakenE;
    logic       dStall;
  } hazInT;

  typedef struct packed {
    logic [1:0] forwardAE;
    logic [1:0] forwardBE;
    logic       stallF;
    logic       stallD;
    logic       stallE;
    logic       stallM;
    logic       flushD;
    logic       flushE;
    logic       flushW;
    logic       stallW;
  } hazOutT;

  typedef struct packed {
    logic               valid;
    logic               write;
    logic [`DATA_W-1:0] addr;
    logic [`DATA_W-1:0] wdata;
  } dReqT;

  typedef struct packed {
    logic               valid;
    logic [3:0]         rd;
    logic [`DATA_W-1:0] data;
  } wbRptT;

endpackage

`default_nettype wire

// ==== rtl/decoder.sv ====
`default_nettype none

`include "core_consts.svh"

module decoder (
  input  wire core_pkg::instrT  instr,
  output core_pkg::deCtrlT      ctrl,
  output logic [3:0]            rn,
  output logic [3:0]            rm,
  output logic [3:0]            rd,
  output logic [`DATA_W-1:0]    imm,
  output logic                  usesRn,
  output logic                  usesRm
);

  import core_pkg::*;

  always_comb
  begin
    // defaults decode to a harmless no-op
    ctrl      = '0;
    ctrl.cond = instr.dp.cond;
    rn        = instr.dp.rn;
    rd        = instr.dp.rd;
    rm        = instr.dp.op2[3:0];
    imm       = '0;
    usesRn    = 1'b0;
    usesRm    = 1'b0;

    case (instr.dp.cls)
      `CLASS_DP:
      begin
        imm           = {{(`DATA_W-8){1'b0}}, instr.dp.op2};
        ctrl.useImm   = instr.dp.isImm;
        ctrl.regWrite = 1'b1;
        usesRn        = 1'b1;
        // register form reads rm from op2
        usesRm        = !instr.dp.isImm;
        case (instr.dp.opcode)
          `OP_ADD: ctrl.aluOp = ALU_ADD;
          `OP_SUB: ctrl.aluOp = ALU_SUB;
          `OP_AND: ctrl.aluOp = ALU_AND;
          `OP_ORR: ctrl.aluOp = ALU_ORR;
          `OP_MOV:
          begin
            // mov ignores rn
            ctrl.aluOp = ALU_PASSB;
            usesRn     = 1'b0;
          end
          `OP_CMP:
          begin
            // flags only, no register result
            ctrl.aluOp    = ALU_SUB;
            ctrl.regWrite = 1'b0;
            ctrl.setFlag  = 1'b1;
          end
          default:
          begin
            ctrl.regWrite = 1'b0;
            usesRn        = 1'b0;
            usesRm        = 1'b0;
          end
        endcase
      end
      `CLASS_MEM:
      begin
        rn          = instr.mem.rn;
        rd          = instr.mem.rd;
        imm         = {{(`DATA_W-12){1'b0}}, instr.mem.offset};
        ctrl.useImm = 1'b1;
        ctrl.aluOp  = ALU_ADD;
        usesRn      = 1'b1;
        if (instr.mem.isLoad)
        begin
          ctrl.memRead  = 1'b1;
          ctrl.regWrite = 1'b1;
        end
        else
        begin
          // store data comes from rd through the B path
          ctrl.memWrite = 1'b1;
          rm            = instr.mem.rd;
          usesRm        = 1'b1;
        end
      end
      `CLASS_BR:
      begin
        // sign-extended word offset, as a byte offset
        imm         = {{(`DATA_W-26){instr.br.offset[23]}}, instr.br.offset, 2'b00};
        ctrl.branch = 1'b1;
        ctrl.useImm = 1'b1;
      end
      default:
      begin
        // unused class stays a no-op
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/hazard.sv ====
`default_nettype none

module hazard (
  input  wire logic            clk,
  input  wire core_pkg::hazInT hazIn,
  output core_pkg::hazOutT     hazOut
);

  logic ldUseD;
  logic takenE;

  // newest producer wins, memory stage before writeback
  always_comb
  begin
    if (hazIn.regWriteM && (hazIn.rdM == hazIn.rnE))
      hazOut.forwardAE = 2'b10;
    else if (hazIn.regWriteW && (hazIn.rdW == hazIn.rnE))
      hazOut.forwardAE = 2'b01;
    else
      hazOut.forwardAE = 2'b00;

    if (hazIn.regWriteM && (hazIn.rdM == hazIn.rmE))
      hazOut.forwardBE = 2'b10;
    else if (hazIn.regWriteW && (hazIn.rdW == hazIn.rmE))
      hazOut.forwardBE = 2'b01;
    else
      hazOut.forwardBE = 2'b00;
  end

  // load in execute feeding a source that decode really reads
  assign ldUseD = hazIn.memReadE &&
                  ((hazIn.usesRnD && (hazIn.rnD == hazIn.rdE)) ||
                   (hazIn.usesRmD && (hazIn.rdE == hazIn.rmD)));

  // a stalled branch waits in execute and resolves once memory is free
  assign takenE = hazIn.branchTakenE && !hazIn.dStall;

  // load-use holds F and D and lets a bubble into E
  assign hazOut.stallF = ldUseD || hazIn.dStall;
  assign hazOut.stallD = ldUseD || hazIn.dStall;
  // data stall freezes everything up to M
  assign hazOut.stallE = hazIn.dStall;
  assign hazOut.stallM = hazIn.dStall;
  // W receives a bubble while M is held
  assign hazOut.flushW = hazIn.dStall;
  // fetch is single-cycle, so W never holds
  assign hazOut.stallW = 1'b0;

  // wrong-path instructions behind a taken branch
  assign hazOut.flushD = takenE;
  assign hazOut.flushE = takenE || (ldUseD && !hazIn.dStall);

  // a held E stage must keep its instruction, not drop it
  assert property (@(posedge clk) !(hazOut.flushE && hazOut.stallE));

endmodule

`default_nettype wire

// ==== rtl/pipeCore.sv ====
`default_nettype none

`include "core_consts.svh"

module pipeCore (
  input  wire logic               clk,
  input  wire logic               rstN,
  output logic      [`DATA_W-1:0] iAddr,
  input  wire core_pkg::instrT    iData,
  output core_pkg::dReqT          dReq,
  input  wire logic [`DATA_W-1:0] dRData,
  input  wire logic               dStall,
  output core_pkg::wbRptT         wbRpt
);

  import core_pkg::*;

  // fetch and decode state
  logic [`DATA_W-1:0] pcF;
  logic [`DATA_W-1:0] pcD;
  instrT              instrD;
  logic               validD;

  // decode outputs
  deCtrlT             decCtrl;
  deCtrlT             ctrlD;
  logic [3:0]         rnD;
  logic [3:0]         rmD;
  logic [3:0]         rdD;
  logic [`DATA_W-1:0] immD;
  logic               usesRnD;
  logic               usesRmD;
  logic [`DATA_W-1:0] rd1D;
  logic [`DATA_W-1:0] rd2D;

  // later stages
  idExT               idEx;
  exMemT              exMem;
  memWbT              memWb;
  logic [`DATA_W-1:0] srcAE;
  logic [`DATA_W-1:0] srcBE;
  logic [`DATA_W-1:0] aluBE;
  logic [`DATA_W-1:0] aluYE;
  logic               aluZeroE;
  logic [`DATA_W-1:0] branchTargetE;
  logic               condPassE;
  logic               branchTakenE;
  logic               zFlag;

  hazInT              hazIn;
  hazOutT             hazOut;

  // fetch
  assign iAddr = pcF;

  // a branch held by a data stall waits for stallF to drop
  always_ff @(posedge clk)
  begin
    if (!rstN)
      pcF <= '0;
    else if (!hazOut.stallF)
      pcF <= branchTakenE ? branchTargetE : pcF + `DATA_W'd4;
  end

  // fetch/decode register, flush wins over stall
  always_ff @(posedge clk)
  begin
    if (!rstN || hazOut.flushD)
      validD <= 1'b0;
    else if (!hazOut.stallD)
      validD <= 1'b1;
    if (!hazOut.stallD)
    begin
      instrD <= iData;
      pcD    <= pcF;
    end
  end

  // decode
  decoder decoder_i (
    .instr  (instrD),
    .ctrl   (decCtrl),
    .rn     (rnD),
    .rm     (rmD),
    .rd     (rdD),
    .imm    (immD),
    .usesRn (usesRnD),
    .usesRm (usesRmD)
  );

  // an empty decode slot carries no control
  assign ctrlD = validD ? decCtrl : '0;

  regFile regFile_i (
    .clk  (clk),
    .rstN (rstN),
    .ra1  (rnD),
    .ra2  (rmD),
    .rd1  (rd1D),
    .rd2  (rd2D),
    .we   (memWb.regWrite),
    .wa   (memWb.rd),
    .wd   (memWb.result)
  );

  // decode/execute register
  always_ff @(posedge clk)
  begin
    if (!rstN || hazOut.flushE)
      idEx.ctrl <= '0;
    else if (!hazOut.stallE)
      idEx.ctrl <= ctrlD;
    if (hazOut.stallE)
    begin
      // keep forwarded values, W is flushed while E waits
      idEx.rnVal <= srcAE;
      idEx.rmVal <= srcBE;
    end
    else
    begin
      idEx.pc    <= pcD;
      idEx.rnVal <= rd1D;
      idEx.rmVal <= rd2D;
      idEx.imm   <= immD;
      idEx.rn    <= rnD;
      idEx.rm    <= rmD;
      idEx.rd    <= rdD;
    end
  end

  // execute operand forwarding
  always_comb
  begin
    case (hazOut.forwardAE)
      2'b10:   srcAE = exMem.aluRes;
      2'b01:   srcAE = memWb.result;
      default: srcAE = idEx.rnVal;
    endcase
    case (hazOut.forwardBE)
      2'b10:   srcBE = exMem.aluRes;
      2'b01:   srcBE = memWb.result;
      default: srcBE = idEx.rmVal;
    endcase
  end

  assign aluBE = idEx.ctrl.useImm ? idEx.imm : srcBE;

  alu alu_i (
    .a    (srcAE),
    .b    (aluBE),
    .op   (idEx.ctrl.aluOp),
    .y    (aluYE),
    .zero (aluZeroE)
  );

  // pc reads two words ahead of the branch, as on ARM
  assign branchTargetE = idEx.pc + `DATA_W'd8 + idEx.imm;

  always_comb
  begin
    case (idEx.ctrl.cond)
      `COND_AL: condPassE = 1'b1;
      `COND_EQ: condPassE = zFlag;
      `COND_NE: condPassE = !zFlag;
      default:  condPassE = 1'b0;
    endcase
  end

  assign branchTakenE = idEx.ctrl.branch && condPassE;

  // only cmp sets Z, once per instruction
  always_ff @(posedge clk)
  begin
    if (!rstN)
      zFlag <= 1'b0;
    else if (idEx.ctrl.setFlag && !hazOut.stallE)
      zFlag <= aluZeroE;
  end

  // execute/memory register
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      exMem.regWrite <= 1'b0;
      exMem.memRead  <= 1'b0;
      exMem.memWrite <= 1'b0;
    end
    else if (!hazOut.stallM)
    begin
      exMem.regWrite <= idEx.ctrl.regWrite;
      exMem.memRead  <= idEx.ctrl.memRead;
      exMem.memWrite <= idEx.ctrl.memWrite;
    end
    if (!hazOut.stallM)
    begin
      exMem.aluRes    <= aluYE;
      exMem.storeData <= srcBE;
      exMem.rd        <= idEx.rd;
    end
  end

  // data port, held steady while dStall is high
  always_comb
  begin
    dReq.valid = exMem.memRead || exMem.memWrite;
    dReq.write = exMem.memWrite;
    dReq.addr  = exMem.aluRes;
    dReq.wdata = exMem.storeData;
  end

  // memory/writeback register
  always_ff @(posedge clk)
  begin
    if (!rstN || hazOut.flushW)
      memWb.regWrite <= 1'b0;
    else if (!hazOut.stallW)
      memWb.regWrite <= exMem.regWrite;
    if (!hazOut.stallW)
    begin
      // load data is sampled in the cycle dStall is low
      memWb.result <= exMem.memRead ? dRData : exMem.aluRes;
      memWb.rd     <= exMem.rd;
    end
  end

  // one report per register write
  always_comb
  begin
    wbRpt.valid = memWb.regWrite;
    wbRpt.rd    = memWb.rd;
    wbRpt.data  = memWb.result;
  end

  // hazard inputs gathered from every stage
  always_comb
  begin
    hazIn.rnD          = rnD;
    hazIn.rmD          = rmD;
    hazIn.usesRnD      = usesRnD && validD;
    hazIn.usesRmD      = usesRmD && validD;
    hazIn.rnE          = idEx.rn;
    hazIn.rmE          = idEx.rm;
    hazIn.rdE          = idEx.rd;
    hazIn.memReadE     = idEx.ctrl.memRead;
    hazIn.rdM          = exMem.rd;
    hazIn.regWriteM    = exMem.regWrite;
    hazIn.rdW          = memWb.rd;
    hazIn.regWriteW    = memWb.regWrite;
    hazIn.branchTakenE = branchTakenE;
    hazIn.dStall       = dStall;
  end

  hazard hazard_i (
    .clk    (clk),
    .hazIn  (hazIn),
    .hazOut (hazOut)
  );

  // decode never issues an access that both reads and writes
  assert property (@(posedge clk) disable iff (!rstN)
    dReq.valid |-> !(exMem.memRead && exMem.memWrite));

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`default_nettype none

`include "core_consts.svh"

module regFile (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire logic [3:0]         ra1,
  input  wire logic [3:0]         ra2,
  output logic      [`DATA_W-1:0] rd1,
  output logic      [`DATA_W-1:0] rd2,
  input  wire logic               we,
  input  wire logic [3:0]         wa,
  input  wire logic [`DATA_W-1:0] wd
);

  logic [`DATA_W-1:0] regs [`REG_CNT];

  // all registers start at zero
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `REG_CNT; i++)
        regs[i] <= '0;
    end
    else if (we)
      regs[wa] <= wd;
  end

  // writeback result bypasses the array in the same cycle
  assign rd1 = (we && (wa == ra1)) ? wd : regs[ra1];
  assign rd2 = (we && (wa == ra2)) ? wd : regs[ra2];

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/core_pkg.sv
rtl/hazard.sv
rtl/regFile.sv
rtl/decoder.sv
rtl/alu.sv
rtl/pipeCore.sv
bench/isaModel.sv
bench/tbCore.sv
